/* design/uart_cfg_pkg.sv */
package uart_cfg_pkg;

    // system clocks per 16x oversampling tick.
    localparam int CLKS_PER_TICK = 4;

    // ticks per serial bit period.
    localparam int OVERSAMPLE = 16;

    // system clocks per serial bit.
    localparam int CLKS_PER_BIT = CLKS_PER_TICK * OVERSAMPLE;

    // width of the tick divider counter.
    localparam int TICK_CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

    // width of the per-bit tick counters in rx and tx.
    localparam int OS_CNT_W = $clog2(OVERSAMPLE);

    // 8N1 payload size.
    localparam int DATA_BITS = 8;

    // data bits plus start and stop.
    localparam int FRAME_BITS = DATA_BITS + 2;

    // width of the tx frame bit counter.
    localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

    // width of the rx data bit counter.
    localparam int DATA_CNT_W = $clog2(DATA_BITS);

endpackage

/* design/uart_types_pkg.sv */
package uart_types_pkg;

    // host transmit request, sampled when tx_ready is high.
    typedef struct packed {
        logic                                valid;
        logic [uart_cfg_pkg::DATA_BITS-1:0]  data;
    } uart_tx_req_t;

    // frame as delivered by the receiver with rx_valid.
    typedef struct packed {
        logic [uart_cfg_pkg::DATA_BITS-1:0]  data;
        logic                                frame_err;
    } uart_rx_frame_t;

    // host-facing receive status register.
    typedef struct packed {
        logic                                valid;
        logic [uart_cfg_pkg::DATA_BITS-1:0]  data;
        logic                                frame_err;
        logic                                overrun;
    } uart_rx_status_t;

endpackage

/* design/uart_baud_tick.sv */
`timescale 1ns/1ps

module uart_baud_tick (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    import uart_cfg_pkg::*;

    logic [TICK_CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == TICK_CNT_W'(CLKS_PER_TICK - 1)) begin
            cnt  <= '0; // wrap and strobe.
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // rx and tx count ticks, so a doubled strobe would skew every bit.
    a_tick_single : assert property (
        @(posedge clk) disable iff (!rst)
        tick |=> !tick
    );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tick,
    input  logic                           rx_line,
    output logic                           rx_valid,
    output uart_types_pkg::uart_rx_frame_t rx_frame
);
    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t                 state;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic [OS_CNT_W-1:0]    os_cnt;
    logic [DATA_CNT_W-1:0]  bit_cnt;
    logic [DATA_BITS-1:0]   shift_reg;
    logic                   fall_edge;

    // two-flop synchronizer, idles high like the line.
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // an edge is needed, so a low stop bit cannot restart a frame by itself.
    assign fall_edge = rx_prev && !rx_sync;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= st_idle;
            os_cnt   <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    os_cnt  <= '0;
                    bit_cnt <= '0;
                    if (fall_edge) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (tick) begin
                        if (os_cnt == OS_CNT_W'(OVERSAMPLE / 2 - 1)) begin
                            os_cnt <= '0;
                            // line back high at mid start bit means a glitch.
                            state  <= rx_sync ? st_idle : st_data;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                end
                st_data: begin
                    if (tick) begin
                        if (os_cnt == OS_CNT_W'(OVERSAMPLE - 1)) begin
                            os_cnt    <= '0;
                            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]}; // lsb first.
                            if (bit_cnt == DATA_CNT_W'(DATA_BITS - 1)) begin
                                state <= st_stop;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (tick) begin
                        if (os_cnt == OS_CNT_W'(OVERSAMPLE - 1)) begin
                            os_cnt             <= '0;
                            rx_valid           <= 1'b1;
                            rx_frame.data      <= shift_reg;
                            rx_frame.frame_err <= !rx_sync; // stop bit must be high.
                            state              <= st_idle;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // the status register counts one byte per pulse.
    a_rx_valid_pulse : assert property (
        @(posedge clk) disable iff (!rst)
        rx_valid |=> !rx_valid
    );

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               tick,
    input  logic                               tx_start,
    input  logic [uart_cfg_pkg::DATA_BITS-1:0] tx_data,
    output logic                               txd,
    output logic                               tx_busy
);
    import uart_cfg_pkg::*;

    logic [FRAME_BITS-1:0]   shift_reg;
    logic [OS_CNT_W-1:0]     os_cnt;
    logic [FRAME_CNT_W-1:0]  bit_cnt;
    logic                    active;

    always_ff @(posedge clk) begin
        if (!rst) begin
            txd     <= 1'b1;
            tx_busy <= 1'b0;
            active  <= 1'b0;
            os_cnt  <= '0;
            bit_cnt <= '0;
        end else if (tx_start) begin
            shift_reg <= {1'b1, tx_data, 1'b0}; // stop, data, start.
            tx_busy   <= 1'b1;
            active    <= 1'b0;
            os_cnt    <= '0;
            bit_cnt   <= '0;
        end else if (tx_busy && tick) begin
            if (!active) begin
                active <= 1'b1; // align frame to the tick grid.
                txd    <= shift_reg[0];
            end else if (os_cnt == OS_CNT_W'(OVERSAMPLE - 1)) begin
                os_cnt <= '0;
                if (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1)) begin
                    tx_busy <= 1'b0; // stop bit fully sent.
                    active  <= 1'b0;
                    txd     <= 1'b1;
                end else begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
                    txd       <= shift_reg[1];
                end
            end else begin
                os_cnt <= os_cnt + 1'b1;
            end
        end
    end

    // the controller must hold new bytes until the frame is out.
    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (!rst)
        tx_start |-> !tx_busy
    );

endmodule

/* design/uart_ctrl.sv */
`timescale 1ns/1ps

module uart_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               loopback,
    input  logic                               rxd,
    input  logic                               txd,
    input  logic                               tx_busy,
    input  logic                               rx_valid,
    input  logic                               rx_ack,
    input  uart_types_pkg::uart_tx_req_t       host_tx,
    input  uart_types_pkg::uart_rx_frame_t     rx_frame,
    output logic                               tx_start,
    output logic                               tx_ready,
    output logic                               rx_line,
    output logic [uart_cfg_pkg::DATA_BITS-1:0] tx_data,
    output uart_types_pkg::uart_rx_status_t    rx_status
);

    logic pending;
    logic accept;

    // pending covers the gap before tx_busy rises.
    assign tx_ready = !pending && !tx_busy;
    assign accept   = host_tx.valid && tx_ready;

    assign rx_line = loopback ? txd : rxd;

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_start <= 1'b0;
            pending  <= 1'b0;
        end else begin
            tx_start <= accept;
            if (accept) begin
                pending <= 1'b1;
            end else if (tx_busy) begin
                pending <= 1'b0; // handed over to the serializer.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tx_data <= host_tx.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_status.valid   <= 1'b0;
            rx_status.overrun <= 1'b0;
        end else if (rx_valid) begin
            rx_status.valid     <= 1'b1;
            rx_status.data      <= rx_frame.data;
            rx_status.frame_err <= rx_frame.frame_err;
            // an ack in the same cycle retires the old byte in time.
            rx_status.overrun   <= rx_status.valid && !rx_ack;
        end else if (rx_ack) begin
            rx_status.valid   <= 1'b0;
            rx_status.overrun <= 1'b0;
        end
    end

    // the serializer has to pick up every start.
    a_start_takes : assert property (
        @(posedge clk) disable iff (!rst)
        tx_start |=> tx_busy
    );

endmodule

/* design/uart_top.sv */
`timescale 1ns/1ps

module uart_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rxd,
    input  logic                            loopback,
    input  logic                            rx_ack,
    input  uart_types_pkg::uart_tx_req_t    host_tx,
    output logic                            txd,
    output logic                            tx_ready,
    output uart_types_pkg::uart_rx_status_t rx_status
);
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    logic                 tick;
    logic                 rx_line;
    logic                 rx_valid;
    uart_rx_frame_t       rx_frame;
    logic                 tx_start;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_busy;

    uart_baud_tick u_baud_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .rx_line  (rx_line),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    uart_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .loopback  (loopback),
        .rxd       (rxd),
        .txd       (txd),
        .tx_busy   (tx_busy),
        .rx_valid  (rx_valid),
        .rx_ack    (rx_ack),
        .host_tx   (host_tx),
        .rx_frame  (rx_frame),
        .tx_start  (tx_start),
        .tx_ready  (tx_ready),
        .rx_line   (rx_line),
        .tx_data   (tx_data),
        .rx_status (rx_status)
    );

endmodule

/* sim/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;
    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    logic            clk;
    logic            rst;
    logic            rxd;
    logic            loopback;
    logic            rx_ack;
    uart_tx_req_t    host_tx;
    logic            txd;
    logic            tx_ready;
    uart_rx_status_t rx_status;

    int          errors;
    logic [31:0] rng_state;

    uart_top u_uart_top (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .loopback  (loopback),
        .rx_ack    (rx_ack),
        .host_tx   (host_tx),
        .txd       (txd),
        .tx_ready  (tx_ready),
        .rx_status (rx_status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic random_byte(output logic [DATA_BITS-1:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[DATA_BITS-1:0];
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_byte(input string what, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rx_status(input string what, input uart_rx_status_t got,
                                   input uart_rx_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got v=%b d=%h fe=%b ov=%b expected v=%b d=%h fe=%b ov=%b",
                     $time, what, got.valid, got.data, got.frame_err, got.overrun,
                     exp.valid, exp.data, exp.frame_err, exp.overrun);
        end
    endtask

    task automatic wait_tx_ready();
        int cnt;
        cnt = 0;
        while (!tx_ready && cnt < 16 * CLKS_PER_BIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!tx_ready) begin
            report_timeout("tx_ready never rose");
        end
    endtask

    task automatic wait_rx_valid();
        int cnt;
        cnt = 0;
        while (!rx_status.valid && cnt < 16 * CLKS_PER_BIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rx_status.valid) begin
            report_timeout("rx_status.valid never rose");
        end
    endtask

    task automatic host_send(input logic [DATA_BITS-1:0] b);
        wait_tx_ready();
        host_tx.valid = 1'b1;
        host_tx.data  = b;
        @(negedge clk);
        host_tx.valid = 1'b0;
        check_level("tx_ready after accept", tx_ready, 1'b0);
    endtask

    task automatic ack_rx();
        rx_ack = 1'b1;
        @(negedge clk);
        rx_ack = 1'b0;
    endtask

    // drives one frame on rxd, then one idle bit.
    task automatic serial_send(input logic [DATA_BITS-1:0] b, input logic stop_low);
        rxd = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            rxd = b[i]; // lsb first.
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rxd = !stop_low;
        repeat (CLKS_PER_BIT) @(negedge clk);
        rxd = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // returns at the centre of the stop bit.
    task automatic serial_capture(output logic [DATA_BITS-1:0] data,
                                  output logic start_bit, output logic stop_bit);
        int cnt;
        cnt = 0;
        while (txd && cnt < 4 * CLKS_PER_BIT) begin
            @(negedge clk);
            cnt++;
        end
        if (txd) begin
            report_timeout("no start bit on txd");
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        start_bit = txd;
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        stop_bit = txd;
    endtask

    task automatic test_transmit();
        logic [DATA_BITS-1:0] b;
        logic [DATA_BITS-1:0] got;
        logic                 start_bit;
        logic                 stop_bit;
        for (int n = 0; n < 4; n++) begin
            random_byte(b);
            host_send(b);
            serial_capture(got, start_bit, stop_bit);
            check_byte("tx data", got, b);
            check_level("tx start bit", start_bit, 1'b0);
            check_level("tx stop bit", stop_bit, 1'b1);
            check_level("tx_ready in stop bit", tx_ready, 1'b0);
            // half a bit on from the stop centre the frame is over.
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_level("tx_ready after frame", tx_ready, 1'b1);
        end
    endtask

    task automatic test_receive();
        logic [DATA_BITS-1:0] b;
        uart_rx_status_t      exp;
        for (int n = 0; n < 4; n++) begin
            random_byte(b);
            serial_send(b, 1'b0);
            wait_rx_valid();
            exp = '{valid: 1'b1, data: b, frame_err: 1'b0, overrun: 1'b0};
            check_rx_status("rx status", rx_status, exp);
            ack_rx();
            check_level("rx valid after ack", rx_status.valid, 1'b0);
        end
    endtask

    task automatic test_frame_error();
        logic [DATA_BITS-1:0] b;
        uart_rx_status_t      exp;
        random_byte(b);
        serial_send(b, 1'b1);
        wait_rx_valid();
        exp = '{valid: 1'b1, data: b, frame_err: 1'b1, overrun: 1'b0};
        check_rx_status("frame error status", rx_status, exp);
        ack_rx();
    endtask

    task automatic test_overrun_glitch();
        logic [DATA_BITS-1:0] a;
        logic [DATA_BITS-1:0] b;
        logic                 seen;
        uart_rx_status_t      exp;
        random_byte(a);
        random_byte(b);
        serial_send(a, 1'b0);
        serial_send(b, 1'b0);
        wait_rx_valid();
        exp = '{valid: 1'b1, data: b, frame_err: 1'b0, overrun: 1'b1};
        check_rx_status("overrun status", rx_status, exp);
        ack_rx();
        exp = '{valid: 1'b0, data: b, frame_err: 1'b0, overrun: 1'b0};
        check_rx_status("status after ack", rx_status, exp);
        rxd = 1'b0; // quarter-bit low pulse.
        repeat (CLKS_PER_BIT / 4) @(negedge clk);
        rxd = 1'b1;
        seen = 1'b0;
        // long enough for a wrongly started frame to complete.
        repeat ((FRAME_BITS + 1) * CLKS_PER_BIT) begin
            @(negedge clk);
            seen = seen | rx_status.valid;
        end
        check_level("valid after glitch", seen, 1'b0);
    endtask

    task automatic test_loopback();
        logic [DATA_BITS-1:0] b;
        uart_rx_status_t      exp;
        loopback = 1'b1;
        @(negedge clk);
        rxd = 1'b0; // external line must be ignored.
        for (int n = 0; n < 4; n++) begin
            random_byte(b);
            host_send(b);
            wait_rx_valid();
            exp = '{valid: 1'b1, data: b, frame_err: 1'b0, overrun: 1'b0};
            check_rx_status("loopback status", rx_status, exp);
            ack_rx();
            wait_tx_ready();
        end
        rxd = 1'b1;
        @(negedge clk);
        loopback = 1'b0;
    endtask

    initial begin
        errors    = 0;
        rng_state = 32'h801a_5281;
        rst       = 1'b0;
        rxd       = 1'b1;
        loopback  = 1'b0;
        rx_ack    = 1'b0;
        host_tx   = '0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        test_transmit();
        test_receive();
        test_frame_error();
        test_overrun_glitch();
        test_loopback();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/uart_cfg_pkg.sv
design/uart_types_pkg.sv
design/uart_baud_tick.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_ctrl.sv
design/uart_top.sv
sim/uart_tb.sv
